// File: arrayMemory.f
hw/arrayMemoryPkg.sv
hw/elementStore.sv
hw/elementAlu.sv
hw/arrayDirectory.sv
hw/commandControl.sv
hw/axiLiteRegs.sv
hw/arrayMemoryTop.sv
tb/arrayMemory_assert.sv
tb/arrayMemoryTb.sv

// File: hw/arrayDirectory.sv
//----------------------------------------------------------------------
// Array directory
// Allocation bits, free-array stack, fresh counter and size table
//----------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ns

module arrayDirectory (
  input  logic                     clock,
  input  logic                     resetN,
  input  arrayMemoryPkg::dirCmd    dirOp,
  input  arrayMemoryPkg::arrayNum  dirArray,
  input  arrayMemoryPkg::sizeCount newSize,
  output logic                     allocated,
  output arrayMemoryPkg::sizeCount curSize,
  output arrayMemoryPkg::arrayNum  allocArray,
  output logic                     allocOk
);
  import arrayMemoryPkg::*;

  logic [arrayCount-1:0] allocBits;
  sizeCount              sizeTable [arrayCount];
  arrayNum               freeStack [arrayCount];   // Most recently freed on top
  logic [arrayBits:0]    freeTop;                  // Entries on the stack
  logic [arrayBits:0]    freshCount;               // Arrays never handed out yet
  logic [arrayBits:0]    topIndex;

  assign topIndex   = freeTop - 1'b1;
  assign allocOk    = (freeTop != '0) || (freshCount < (arrayBits + 1)'(arrayCount));
  assign allocArray = (freeTop != '0) ? freeStack[topIndex[arrayBits-1:0]]
                                      : freshCount[arrayBits-1:0];
  assign allocated  = allocBits[dirArray];
  assign curSize    = sizeTable[dirArray];

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      allocBits  <= '0;
      freeTop    <= '0;
      freshCount <= '0;
      for (int i = 0; i < arrayCount; i++) begin
        sizeTable[i] <= '0;
      end
    end else begin
      case (dirOp)
        dirReset: begin                            // Drop every array
          allocBits  <= '0;
          freeTop    <= '0;
          freshCount <= '0;
        end
        dirAlloc: begin
          if (allocOk) begin
            allocBits[allocArray] <= 1'b1;
            sizeTable[allocArray] <= '0;          // New array starts empty
            if (freeTop != '0) begin
              freeTop <= topIndex;
            end else begin
              freshCount <= freshCount + 1'b1;
            end
          end
        end
        dirFree: begin
          allocBits[dirArray] <= 1'b0;
          freeTop             <= freeTop + 1'b1;
        end
        dirSetSize: sizeTable[dirArray] <= newSize;
        dirClear:   sizeTable[dirArray] <= '0;
        default:    allocBits <= allocBits;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (dirOp == dirFree) begin
      freeStack[freeTop[arrayBits-1:0]] <= dirArray;
    end
  end

endmodule

`default_nettype wire

// File: hw/arrayMemoryPkg.sv
//----------------------------------------------------------------------
// Array memory unit definitions
// Sizes, opcodes, error codes, register map and the command layout
//----------------------------------------------------------------------
`default_nettype none

package arrayMemoryPkg;

  //--------------------------------------------------------------------
  // Sizes
  //--------------------------------------------------------------------
  localparam int arrayBits   = 2;                  // Bits in an array number
  localparam int indexBits   = 3;                  // Bits in an element index
  localparam int dataBits    = 16;                 // Width of one element
  localparam int arrayCount  = 1 << arrayBits;     // Arrays in the pool
  localparam int arrayLength = 1 << indexBits;     // Elements per array

  typedef logic [arrayBits-1:0]           arrayNum;
  typedef logic [indexBits-1:0]           elemIndex;
  typedef logic [indexBits:0]             sizeCount;   // 0 to arrayLength
  typedef logic [dataBits-1:0]            dataWord;
  typedef logic [arrayBits+indexBits-1:0] storeAddr;   // Array and index joined

  //--------------------------------------------------------------------
  // Commands and errors
  //--------------------------------------------------------------------
  typedef enum logic [4:0] {
    opReset   = 5'd0,
    opAlloc   = 5'd1,
    opFree    = 5'd2,
    opWrite   = 5'd3,
    opRead    = 5'd4,
    opSize    = 5'd5,
    opPush    = 5'd6,
    opPop     = 5'd7,
    opAdd     = 5'd8,
    opSub     = 5'd9,
    opAnd     = 5'd10,
    opOr      = 5'd11,
    opXor     = 5'd12,
    opLess    = 5'd13,
    opGreater = 5'd14
  } opCode;

  typedef enum logic [2:0] {
    errNone         = 3'd0,
    errNotAllocated = 3'd1,
    errOutOfBounds  = 3'd2,
    errFull         = 3'd3,
    errEmpty        = 3'd4,
    errOutOfMemory  = 3'd5
  } errCode;

  // Directory request from the command FSM
  typedef enum logic [2:0] {
    dirNone, dirReset, dirAlloc, dirFree, dirSetSize, dirClear
  } dirCmd;

  typedef struct packed {
    opCode    op;
    arrayNum  array;
    elemIndex index;
    dataWord  data;                                // From the data register
  } command;

  //--------------------------------------------------------------------
  // AXI4-Lite register map
  //--------------------------------------------------------------------
  typedef logic [3:0]  axiAddr;
  typedef logic [31:0] axiWord;
  typedef logic [3:0]  axiStrb;
  typedef logic [1:0]  axiResp;

  localparam axiAddr addrData    = 4'h0;
  localparam axiAddr addrCommand = 4'h4;
  localparam axiAddr addrResult  = 4'h8;
  localparam axiAddr addrStatus  = 4'hC;

  localparam axiResp respOkay   = 2'b00;
  localparam axiResp respSlvErr = 2'b10;

endpackage

`default_nettype wire

// File: hw/arrayMemoryTop.sv
//----------------------------------------------------------------------
// Array memory unit top level
// AXI4-Lite front end, command FSM, directory, store and ALU
//----------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ns

module arrayMemoryTop (
  input  logic                   clock,
  input  logic                   resetN,
  input  arrayMemoryPkg::axiAddr awaddr,
  input  logic                   awvalid,
  output logic                   awready,
  input  arrayMemoryPkg::axiWord wdata,
  input  arrayMemoryPkg::axiStrb wstrb,
  input  logic                   wvalid,
  output logic                   wready,
  output arrayMemoryPkg::axiResp bresp,
  output logic                   bvalid,
  input  logic                   bready,
  input  arrayMemoryPkg::axiAddr araddr,
  input  logic                   arvalid,
  output logic                   arready,
  output arrayMemoryPkg::axiWord rdata,
  output arrayMemoryPkg::axiResp rresp,
  output logic                   rvalid,
  input  logic                   rready
);
  import arrayMemoryPkg::*;

  command   cmd;
  logic     cmdValid;
  logic     busy;
  dataWord  result;
  errCode   err;
  dirCmd    dirOp;
  arrayNum  dirArray;
  arrayNum  allocArray;
  sizeCount newSize;
  sizeCount curSize;
  logic     allocated;
  logic     allocOk;
  logic     rdEn;
  logic     wrEn;
  storeAddr addr;
  dataWord  wrData;
  dataWord  rdData;
  opCode    aluOp;
  dataWord  elem;
  dataWord  operand;
  dataWord  updated;
  logic     less;
  logic     greater;

  axiLiteRegs u_regs (
    .clock, .resetN,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .cmd, .cmdValid, .busy, .result, .err
  );

  commandControl u_control (
    .clock, .resetN, .cmd, .cmdValid, .busy, .result, .err,
    .dirOp, .dirArray, .newSize, .allocated, .curSize, .allocArray, .allocOk,
    .rdEn, .wrEn, .addr, .wrData, .rdData,
    .aluOp, .elem, .operand, .updated, .less, .greater
  );

  arrayDirectory u_directory (
    .clock, .resetN, .dirOp, .dirArray, .newSize,
    .allocated, .curSize, .allocArray, .allocOk
  );

  elementStore u_store (
    .clock, .rdEn, .wrEn, .addr, .wrData, .rdData
  );

  elementAlu u_alu (
    .op(aluOp), .elem, .operand, .updated, .less, .greater
  );

endmodule

`default_nettype wire

// File: hw/axiLiteRegs.sv
//----------------------------------------------------------------------
// AXI4-Lite slave for the array memory unit
// Holds the data register, issues commands and returns result and status
//----------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ns

module axiLiteRegs (
  input  logic                    clock,
  input  logic                    resetN,
  input  arrayMemoryPkg::axiAddr  awaddr,
  input  logic                    awvalid,
  output logic                    awready,
  input  arrayMemoryPkg::axiWord  wdata,
  input  arrayMemoryPkg::axiStrb  wstrb,
  input  logic                    wvalid,
  output logic                    wready,
  output arrayMemoryPkg::axiResp  bresp,
  output logic                    bvalid,
  input  logic                    bready,
  input  arrayMemoryPkg::axiAddr  araddr,
  input  logic                    arvalid,
  output logic                    arready,
  output arrayMemoryPkg::axiWord  rdata,
  output arrayMemoryPkg::axiResp  rresp,
  output logic                    rvalid,
  input  logic                    rready,
  output arrayMemoryPkg::command  cmd,
  output logic                    cmdValid,
  input  logic                    busy,
  input  arrayMemoryPkg::dataWord result,
  input  arrayMemoryPkg::errCode  err
);
  import arrayMemoryPkg::*;

  dataWord dataReg;                                // Operand for the next command
  logic    writeFire;
  logic    readFire;
  logic    cmdWrite;
  axiWord  readWord;

  //--------------------------------------------------------------------
  // Write channel
  //--------------------------------------------------------------------
  assign writeFire = awvalid && wvalid && !bvalid; // Both halves present, no response owed
  assign awready   = writeFire;
  assign wready    = writeFire;
  assign cmdWrite  = writeFire && (awaddr == addrCommand);
  assign cmdValid  = cmdWrite && !busy;            // Dropped when a command is running

  // Op in 4:0, array in 9:8, index in 18:16
  assign cmd = '{
    op:    opCode'(wdata[4:0]),
    array: wdata[9:8],
    index: wdata[18:16],
    data:  dataReg
  };

  //--------------------------------------------------------------------
  // Read channel
  //--------------------------------------------------------------------
  assign arready  = !rvalid;                       // One read in flight
  assign readFire = arvalid && arready;
  assign rresp    = respOkay;

  always_comb begin
    readWord = '0;
    case (araddr)
      addrData:   readWord[dataBits-1:0] = dataReg;
      addrResult: readWord[dataBits-1:0] = result;
      addrStatus: begin
        readWord[0]   = busy;
        readWord[6:4] = err;
      end
      default:    readWord = '0;
    endcase
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      bvalid <= 1'b0;
      rvalid <= 1'b0;
    end else begin
      if (writeFire) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
      if (readFire) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (writeFire) begin
      bresp <= (cmdWrite && busy) ? respSlvErr : respOkay;
    end
    if (writeFire && awaddr == addrData) begin
      for (int b = 0; b < dataBits / 8; b++) begin
        if (wstrb[b]) begin
          dataReg[b*8 +: 8] <= wdata[b*8 +: 8];   // Byte lanes
        end
      end
    end
    if (readFire) begin
      rdata <= readWord;
    end
  end

endmodule

`default_nettype wire

// File: hw/commandControl.sv
//----------------------------------------------------------------------
// Command FSM for the array memory unit
// Checks operands, drives directory, store and ALU, counts scan hits
//----------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ns

module commandControl (
  input  logic                     clock,
  input  logic                     resetN,
  input  arrayMemoryPkg::command   cmd,
  input  logic                     cmdValid,
  output logic                     busy,
  output arrayMemoryPkg::dataWord  result,
  output arrayMemoryPkg::errCode   err,
  output arrayMemoryPkg::dirCmd    dirOp,
  output arrayMemoryPkg::arrayNum  dirArray,
  output arrayMemoryPkg::sizeCount newSize,
  input  logic                     allocated,
  input  arrayMemoryPkg::sizeCount curSize,
  input  arrayMemoryPkg::arrayNum  allocArray,
  input  logic                     allocOk,
  output logic                     rdEn,
  output logic                     wrEn,
  output arrayMemoryPkg::storeAddr addr,
  output arrayMemoryPkg::dataWord  wrData,
  input  arrayMemoryPkg::dataWord  rdData,
  output arrayMemoryPkg::opCode    aluOp,
  output arrayMemoryPkg::dataWord  elem,
  output arrayMemoryPkg::dataWord  operand,
  input  arrayMemoryPkg::dataWord  updated,
  input  logic                     less,
  input  logic                     greater
);
  import arrayMemoryPkg::*;

  typedef enum logic [1:0] {idle, readWait, update, scan} ctlState;

  ctlState  state;
  opCode    curOp;                                 // Command held past idle
  arrayNum  curArray;
  elemIndex curIndex;
  dataWord  curData;
  elemIndex scanIdx;
  sizeCount count;
  errCode   checkErr;
  sizeCount writeSize;
  sizeCount popSize;
  logic     hit;
  logic     start;

  assign start     = (state == idle) && cmdValid;
  assign dirArray  = (state == idle) ? cmd.array : curArray;
  assign writeSize = {1'b0, cmd.index} + 1'b1;
  assign popSize   = curSize - 1'b1;
  assign aluOp     = curOp;
  assign elem      = rdData;
  assign operand   = curData;
  // Only the first curSize elements count
  assign hit = ({1'b0, scanIdx} < curSize) && ((curOp == opLess) ? less : greater);

  //--------------------------------------------------------------------
  // Operand checks
  //--------------------------------------------------------------------
  always_comb begin
    checkErr = errNone;
    case (cmd.op)
      opReset: checkErr = errNone;
      opAlloc: checkErr = allocOk ? errNone : errOutOfMemory;
      default: begin
        if (!allocated) begin
          checkErr = errNotAllocated;
        end else begin
          case (cmd.op)
            opRead, opAdd, opSub, opAnd, opOr, opXor:
              if (cmd.index >= curSize) checkErr = errOutOfBounds;
            opPush: if (curSize == sizeCount'(arrayLength)) checkErr = errFull;
            opPop:  if (curSize == '0) checkErr = errEmpty;
            default: checkErr = errNone;
          endcase
        end
      end
    endcase
  end

  //--------------------------------------------------------------------
  // Datapath requests
  //--------------------------------------------------------------------
  always_comb begin
    dirOp   = dirNone;
    newSize = curSize;
    rdEn    = 1'b0;
    wrEn    = 1'b0;
    addr    = {dirArray, cmd.index};
    wrData  = cmd.data;
    case (state)
      idle: begin
        if (cmdValid && checkErr == errNone) begin
          case (cmd.op)
            opReset: dirOp = dirReset;
            opAlloc: dirOp = dirAlloc;
            opFree:  dirOp = dirFree;
            opWrite: begin
              wrEn    = 1'b1;
              dirOp   = dirSetSize;
              newSize = (writeSize > curSize) ? writeSize : curSize;
            end
            opPush: begin
              wrEn    = 1'b1;
              addr    = {cmd.array, curSize[indexBits-1:0]};
              dirOp   = dirSetSize;
              newSize = curSize + 1'b1;
            end
            opPop: begin                           // Shrink first, then read the top
              rdEn    = 1'b1;
              addr    = {cmd.array, popSize[indexBits-1:0]};
              dirOp   = dirSetSize;
              newSize = popSize;
            end
            opRead, opAdd, opSub, opAnd, opOr, opXor: rdEn = 1'b1;
            opLess, opGreater: begin
              rdEn = 1'b1;
              addr = {cmd.array, elemIndex'(0)};  // First element of the scan
            end
            default: dirOp = dirNone;
          endcase
        end
      end
      update: begin
        wrEn   = 1'b1;
        addr   = {curArray, curIndex};
        wrData = updated;
      end
      scan: begin
        rdEn = 1'b1;
        addr = {curArray, scanIdx + 1'b1};         // Prefetch the next element
      end
      default: rdEn = 1'b0;
    endcase
  end

  //--------------------------------------------------------------------
  // FSM
  //--------------------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      state   <= idle;
      busy    <= 1'b0;
      err     <= errNone;
      result  <= '0;
      scanIdx <= '0;
      count   <= '0;
    end else begin
      case (state)
        idle: begin
          busy <= cmdValid;                        // Falls once back here
          if (cmdValid) begin
            err     <= checkErr;
            scanIdx <= '0;
            count   <= '0;
            if (checkErr == errNone) begin
              case (cmd.op)
                opAlloc: result <= dataWord'(allocArray);
                opSize:  result <= dataWord'(curSize);
                opWrite: result <= cmd.data;
                opRead, opPush, opPop: state <= readWait;
                opAdd, opSub, opAnd, opOr, opXor: state <= update;
                opLess, opGreater: state <= scan;
                default: state <= idle;
              endcase
            end
          end
        end
        readWait: begin
          result <= (curOp == opPush) ? curData : rdData;
          state  <= idle;
        end
        update: begin
          result <= updated;                       // New value is returned
          state  <= idle;
        end
        scan: begin
          scanIdx <= scanIdx + 1'b1;
          count   <= count + sizeCount'(hit);
          if (scanIdx == elemIndex'(arrayLength - 1)) begin
            result <= dataWord'(count + sizeCount'(hit));
            state  <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (start) begin
      curOp    <= cmd.op;
      curArray <= cmd.array;
      curIndex <= cmd.index;
      curData  <= cmd.data;
    end
  end

endmodule

`default_nettype wire

// File: hw/elementAlu.sv
//----------------------------------------------------------------------
// Element ALU
// In-place update operations and unsigned compares on one element
//----------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ns

module elementAlu (
  input  arrayMemoryPkg::opCode   op,
  input  arrayMemoryPkg::dataWord elem,
  input  arrayMemoryPkg::dataWord operand,
  output arrayMemoryPkg::dataWord updated,
  output logic                    less,
  output logic                    greater
);
  import arrayMemoryPkg::*;

  always_comb begin
    case (op)
      opAdd:   updated = elem + operand;           // Wraps at the word width
      opSub:   updated = elem - operand;
      opAnd:   updated = elem & operand;
      opOr:    updated = elem | operand;
      opXor:   updated = elem ^ operand;
      default: updated = elem;
    endcase
  end

  assign less    = elem < operand;                 // Unsigned
  assign greater = elem > operand;

endmodule

`default_nettype wire

// File: hw/elementStore.sv
//----------------------------------------------------------------------
// Element store
// All array elements, one synchronous read port and one write port
//----------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ns

module elementStore (
  input  logic                     clock,
  input  logic                     rdEn,
  input  logic                     wrEn,
  input  arrayMemoryPkg::storeAddr addr,
  input  arrayMemoryPkg::dataWord  wrData,
  output arrayMemoryPkg::dataWord  rdData
);
  import arrayMemoryPkg::*;

  dataWord mem [arrayCount * arrayLength];         // Array number in the upper bits

  always_ff @(posedge clock) begin
    if (wrEn) begin
      mem[addr] <= wrData;
    end
    if (rdEn) begin
      rdData <= mem[addr];                         // Ready the following cycle
    end
  end

endmodule

`default_nettype wire

// File: runSim.sh
#!/usr/bin/env bash
# Compile the array memory testbench with Verilator and run it
# The exit status is the simulator's, nonzero on any failure

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
  --top-module arrayMemoryTb -f arrayMemory.f -o arrayMemorySim &&
./obj_dir/arrayMemorySim ||
{ echo "Simulation build or run failed"; exit 1; }

// File: tb/arrayMemoryTb.sv
//----------------------------------------------------------------------
// Array memory unit testbench
// Replays the golden command list over AXI4-Lite and checks each answer
//----------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ns

module arrayMemoryTb;
  import arrayMemoryPkg::*;

  localparam int          clockPeriod   = 20;
  localparam int          resetCycles   = 4;
  localparam int          cyclesPerLine = 40;          // Watchdog budget per command
  localparam int unsigned randomSeed    = 32'h735e_f19b;

  typedef struct packed {
    opCode    op;
    arrayNum  array;
    elemIndex index;
    dataWord  data;
    dataWord  result;
    errCode   err;
  } goldenLine;

  logic   clock;
  logic   resetN;
  axiAddr awaddr;
  logic   awvalid;
  logic   awready;
  axiWord wdata;
  axiStrb wstrb;
  logic   wvalid;
  logic   wready;
  axiResp bresp;
  logic   bvalid;
  logic   bready;
  axiAddr araddr;
  logic   arvalid;
  logic   arready;
  axiWord rdata;
  axiResp rresp;
  logic   rvalid;
  logic   rready;

  goldenLine lines[$];
  string     lineNames[$];
  logic      loaded;
  int        errorCount;

  arrayMemoryTop u_dut (
    .clock, .resetN,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready
  );

  bind arrayMemoryTop arrayMemoryCheck u_check (
    .clock, .resetN, .awaddr, .awvalid, .awready, .wvalid, .wready,
    .bresp, .bvalid, .bready, .arvalid, .arready, .rvalid, .rready, .busy
  );

  initial begin
    clock = 1'b0;
    forever #(clockPeriod / 2) clock = ~clock;
  end

  // Watchdog sized from the number of golden lines
  initial begin
    wait (loaded);
    repeat (resetCycles + cyclesPerLine * lines.size()) @(posedge clock);
    $display("Watchdog expired before the golden list finished");
    abortRun();
  end

  //--------------------------------------------------------------------
  // Helpers
  //--------------------------------------------------------------------
  task automatic abortRun();
    $display("SOME TESTS FAILED");
    $fatal(1, "Run stopped on the first failure");
  endtask

  task automatic checkValue(string testName, string what, axiWord expected, axiWord actual);
    if (actual !== expected) begin
      errorCount++;
      $display("[ERROR] %s %s: expected %0h, actual %0h", testName, what, expected, actual);
      abortRun();
    end
  endtask

  task automatic axiWrite(axiAddr addr, axiWord data, output axiResp resp);
    @(negedge clock);
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    @(posedge clock);
    while (!(awready && wready)) @(posedge clock);
    @(negedge clock);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    repeat ($urandom_range(3, 0)) @(negedge clock);  // Response back-pressure
    bready = 1'b1;
    @(posedge clock);
    while (!bvalid) @(posedge clock);
    resp = bresp;
    @(negedge clock);
    bready = 1'b0;
  endtask

  task automatic axiRead(string testName, axiAddr addr, output axiWord data);
    axiResp resp;
    @(negedge clock);
    araddr  = addr;
    arvalid = 1'b1;
    @(posedge clock);
    while (!arready) @(posedge clock);
    @(negedge clock);
    arvalid = 1'b0;
    repeat ($urandom_range(3, 0)) @(negedge clock);
    rready = 1'b1;
    @(posedge clock);
    while (!rvalid) @(posedge clock);
    data = rdata;
    resp = rresp;
    @(negedge clock);
    rready = 1'b0;
    checkValue(testName, "read response", axiWord'(respOkay), axiWord'(resp));
  endtask

  task automatic loadGolden();
    int        fd;
    int        fields;
    string     text;
    string     name;
    int        op;
    int        arr;
    int        index;
    int        data;
    int        result;
    int        err;
    goldenLine entry;
    fd = $fopen("tb/arrayMemory_golden.txt", "r");
    if (fd == 0) begin
      $display("Could not open tb/arrayMemory_golden.txt");
      abortRun();
    end
    while (!$feof(fd)) begin
      text = "";
      void'($fgets(text, fd));
      if (text.len() < 2 || text[0] == "#") begin
        continue;                                      // Blank or column notes
      end
      fields = $sscanf(text, "%s %h %h %h %h %h %h", name, op, arr, index, data, result, err);
      if (fields != 7) begin
        $display("Golden line could not be parsed: %s", text);
        abortRun();
      end
      entry.op     = opCode'(op);
      entry.array  = arrayNum'(arr);
      entry.index  = elemIndex'(index);
      entry.data   = dataWord'(data);
      entry.result = dataWord'(result);
      entry.err    = errCode'(err);
      lines.push_back(entry);
      lineNames.push_back(name);
    end
    $fclose(fd);
    loaded = 1'b1;
  endtask

  task automatic runLine(string name, goldenLine entry);
    axiWord cmdWord;
    axiWord status;
    axiWord resultWord;
    axiResp resp;
    cmdWord        = '0;
    cmdWord[4:0]   = entry.op;
    cmdWord[9:8]   = entry.array;
    cmdWord[18:16] = entry.index;
    axiWrite(addrData, axiWord'(entry.data), resp);
    checkValue(name, "data write response", axiWord'(respOkay), axiWord'(resp));
    axiWrite(addrCommand, cmdWord, resp);
    checkValue(name, "command write response", axiWord'(respOkay), axiWord'(resp));
    if (entry.op == opLess || entry.op == opGreater) begin
      // A Reset sent during the scan must be refused and leave no trace
      axiWrite(addrCommand, '0, resp);
      checkValue(name, "response while busy", axiWord'(respSlvErr), axiWord'(resp));
    end
    axiRead(name, addrStatus, status);
    while (status[0]) begin
      axiRead(name, addrStatus, status);
    end
    axiRead(name, addrResult, resultWord);
    axiRead(name, addrStatus, status);
    checkValue(name, "error code", axiWord'(entry.err), axiWord'(status[6:4]));
    if (entry.err == errNone) begin
      checkValue(name, "result", axiWord'(entry.result), resultWord);
    end
  endtask

  //--------------------------------------------------------------------
  // Main sequence
  //--------------------------------------------------------------------
  initial begin
    axiWord status;
    resetN     = 1'b0;
    awaddr     = '0;
    awvalid    = 1'b0;
    wdata      = '0;
    wstrb      = 4'hF;                                 // Full words only
    wvalid     = 1'b0;
    bready     = 1'b0;
    araddr     = '0;
    arvalid    = 1'b0;
    rready     = 1'b0;
    loaded     = 1'b0;
    errorCount = 0;
    void'($urandom(randomSeed));
    loadGolden();
    repeat (resetCycles) @(negedge clock);
    resetN = 1'b1;
    axiRead("afterReset", addrStatus, status);
    checkValue("afterReset", "status", '0, status);   // Idle with no error
    for (int i = 0; i < lines.size(); i++) begin
      runLine(lineNames[i], lines[i]);
    end
    if (errorCount == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      abortRun();
    end
  end

endmodule

`default_nettype wire

// File: tb/arrayMemory_assert.sv
//----------------------------------------------------------------------
// Array memory checker, bound into the top level
// AXI4-Lite valid holding, busy length and write response rules
//----------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ns

module arrayMemoryCheck (
  input logic                   clock,
  input logic                   resetN,
  input arrayMemoryPkg::axiAddr awaddr,
  input logic                   awvalid,
  input logic                   awready,
  input logic                   wvalid,
  input logic                   wready,
  input arrayMemoryPkg::axiResp bresp,
  input logic                   bvalid,
  input logic                   bready,
  input logic                   arvalid,
  input logic                   arready,
  input logic                   rvalid,
  input logic                   rready,
  input logic                   busy
);
  import arrayMemoryPkg::*;

  logic [indexBits+1:0] busyCycles;                  // Cycles busy has been seen high

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      busyCycles <= '0;
    end else if (busy) begin
      busyCycles <= busyCycles + 1'b1;
    end else begin
      busyCycles <= '0;
    end
  end

  //--------------------------------------------------------------------
  // Valid stays up until ready
  //--------------------------------------------------------------------
  awHold: assert property (@(posedge clock) disable iff (!resetN)
    awvalid && !awready |=> awvalid) else $error("awvalid dropped before awready");
  wHold: assert property (@(posedge clock) disable iff (!resetN)
    wvalid && !wready |=> wvalid) else $error("wvalid dropped before wready");
  bHold: assert property (@(posedge clock) disable iff (!resetN)
    bvalid && !bready |=> bvalid) else $error("bvalid dropped before bready");
  arHold: assert property (@(posedge clock) disable iff (!resetN)
    arvalid && !arready |=> arvalid) else $error("arvalid dropped before arready");
  rHold: assert property (@(posedge clock) disable iff (!resetN)
    rvalid && !rready |=> rvalid) else $error("rvalid dropped before rready");

  // Longest command is a full scan
  busyLength: assert property (@(posedge clock) disable iff (!resetN)
    busy |-> busyCycles < (arrayLength + 1)) else $error("busy held too long");

  // SLVERR only for a command write that meets a running command
  slvErrCause: assert property (@(posedge clock) disable iff (!resetN)
    awvalid && awready && !(awaddr == addrCommand && busy) |=> bresp == respOkay)
    else $error("unexpected SLVERR on a write");

endmodule

`default_nettype wire

// File: tb/arrayMemory_golden.txt
# name op array index data result err, all fields after the name in hex
# op and err use the package encodings, result is compared only when err is 0
resetAll 0 0 0 0000 0000 0
alloc0 1 0 0 0000 0000 0
alloc1 1 0 0 0000 0001 0
alloc2 1 0 0 0000 0002 0
alloc3 1 0 0 0000 0003 0
allocFull 1 0 0 0000 0000 5
free2 2 2 0 0000 0003 0
reuse2 1 0 0 0000 0002 0
write5 3 2 5 1234 1234 0
size2 5 2 0 0000 0006 0
read5 4 2 5 0000 1234 0
read6 4 2 6 0000 0000 2
free1 2 1 0 0000 1234 0
sizeFreed 5 1 0 0000 0000 1
push6 6 2 0 0f0f 0f0f 0
push7 6 2 0 8001 8001 0
pushFull 6 2 0 7777 0000 3
pop7 7 2 0 0000 8001 0
pop6 7 2 0 0000 0f0f 0
popEmpty 7 3 0 0000 0000 4
add5 8 2 5 f000 0234 0
sub5 9 2 5 0235 ffff 0
and5 a 2 5 0ff0 0ff0 0
or5 b 2 5 4001 4ff1 0
xor5 c 2 5 0f0f 40fe 0
readBack5 4 2 5 0000 40fe 0
pushA 6 3 0 0010 0010 0
pushB 6 3 0 8000 8000 0
pushC 6 3 0 0005 0005 0
lessThan10 d 3 0 0010 0001 0
greaterThan5 e 3 0 0005 0002 0
